// File: tile_loader_params.svh
`ifndef TILE_LOADER_PARAMS_SVH
`define TILE_LOADER_PARAMS_SVH

// Tile geometry
`define TILE_DIM 32
`define ROW_W 5

// One tile row per DMA beat
`define BEAT_W 256
`define BEAT_BYTES 32

// Host side
`define ADDR_W 32
`define DIM_W 16

`endif

// File: tile_loader_pkg.sv
`include "tile_loader_params.svh"

package tile_loader_pkg;

    typedef enum logic {
        OPERAND_A = 1'b0,
        OPERAND_B = 1'b1
    } operand_e;

    // Job as accepted by the decode stage
    typedef struct packed {
        logic [`ADDR_W-1:0] base_a;
        logic [`ADDR_W-1:0] base_b;
        logic [`DIM_W-1:0]  m;
        logic [`DIM_W-1:0]  n;
        logic               mode_a;   // 0 row layout, 1 column layout
        logic               mode_b;
        logic [`DIM_W-1:0]  m_tiles;
        logic [`DIM_W-1:0]  n_tiles;
    } job_t;

endpackage

// File: job_if.sv
`timescale 1ns/10ps

interface job_if;

    tile_loader_pkg::job_t job;   // Stable from go until next go
    logic                  go;

    modport decode (
        output job,
        output go
    );

    modport seq (
        input job,
        input go
    );

    modport mask (
        input job,
        input go
    );

endinterface

// File: tile_if.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

interface tile_if;

    logic                       beat;   // Accepted DMA beat
    tile_loader_pkg::operand_e  sel;
    logic [`ROW_W-1:0]          row;
    logic [`DIM_W-1:0]          base;   // First element of the tile
    logic                       last;   // Final beat of the job

    modport seq (
        output beat, sel, row, base, last
    );

    modport mask (
        input beat, sel, row, base, last
    );

endinterface

// File: job_decode.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

module job_decode (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic [`ADDR_W-1:0] addr_base_a,
    input  logic [`ADDR_W-1:0] addr_base_b,
    input  logic [`DIM_W-1:0]  m,
    input  logic [`DIM_W-1:0]  n,
    input  logic               mode_a,
    input  logic               mode_b,
    input  logic               busy,
    output logic               job_error,
    job_if.decode              job
);

    logic              accept;
    logic              dims_ok;
    logic [`DIM_W-1:0] m_tiles;
    logic [`DIM_W-1:0] n_tiles;

    assign accept  = start && !busy;   // Start while busy is dropped
    assign dims_ok = (m != '0) && (n != '0);

    // Ceiling division by the tile size
    assign m_tiles = (m >> `ROW_W) + `DIM_W'(|m[`ROW_W-1:0]);
    assign n_tiles = (n >> `ROW_W) + `DIM_W'(|n[`ROW_W-1:0]);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            job.go    <= 1'b0;
            job_error <= 1'b0;
        end else begin
            job.go    <= accept && dims_ok;
            job_error <= accept && !dims_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && dims_ok) begin
            job.job <= '{
                base_a:  addr_base_a,
                base_b:  addr_base_b,
                m:       m,
                n:       n,
                mode_a:  mode_a,
                mode_b:  mode_b,
                m_tiles: m_tiles,
                n_tiles: n_tiles
            };
        end
    end

    a_no_go_with_error: assert property (
        @(posedge clk) disable iff (!rstn)
        !(job.go && job_error)
    );

endmodule

// File: tile_sequencer.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

module tile_sequencer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               dma_valid,
    output logic               dma_req,
    output logic [`ADDR_W-1:0] dma_addr,
    output logic               busy,
    output logic               done,
    job_if.seq                 job,
    tile_if.seq                tile
);

    typedef enum logic [2:0] {
        IDLE,
        REQ_A,
        LOAD_A,
        REQ_B,
        LOAD_B
    } state_e;

    state_e            state;
    logic [`DIM_W-1:0] m_idx;
    logic [`DIM_W-1:0] n_idx;
    logic [`ROW_W-1:0] beat_cnt;
    logic              in_load;
    logic              b_side;
    logic              beat;
    logic              tile_end;
    logic              last_m;
    logic              last_n;
    logic              last_beat;
    logic [`DIM_W-1:0] cur_idx;

    assign in_load  = (state == LOAD_A) || (state == LOAD_B);
    assign b_side   = (state == REQ_B) || (state == LOAD_B);
    assign beat     = dma_valid && in_load;
    assign tile_end = beat && (beat_cnt == `ROW_W'(`TILE_DIM - 1));
    assign last_m   = (m_idx == job.job.m_tiles - 1'b1);
    assign last_n   = (n_idx == job.job.n_tiles - 1'b1);
    assign last_beat = tile_end && (state == LOAD_B) && last_m && last_n;

    // A walks m tiles, B walks n tiles
    assign cur_idx = b_side ? n_idx : m_idx;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            m_idx    <= '0;
            n_idx    <= '0;
            beat_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= last_beat;
            if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;   // Wraps at tile end
            end
            case (state)
                IDLE: begin
                    if (job.go) begin
                        m_idx    <= '0;
                        n_idx    <= '0;
                        beat_cnt <= '0;
                        state    <= REQ_A;
                    end
                end
                REQ_A:  state <= LOAD_A;
                LOAD_A: begin
                    if (tile_end) begin
                        state <= REQ_B;
                    end
                end
                REQ_B:  state <= LOAD_B;
                LOAD_B: begin
                    if (tile_end) begin
                        if (!last_n) begin
                            n_idx <= n_idx + 1'b1;
                            state <= REQ_A;
                        end else begin
                            n_idx <= '0;   // Inner loop wraps
                            if (last_m) begin
                                state <= IDLE;
                            end else begin
                                m_idx <= m_idx + 1'b1;
                                state <= REQ_A;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign dma_req  = (state == REQ_A) || (state == REQ_B);
    assign dma_addr = (b_side ? job.job.base_b : job.job.base_a)
                    + `ADDR_W'(cur_idx) * `ADDR_W'(`TILE_DIM * `BEAT_BYTES);

    // Covers the go cycle and the done cycle
    assign busy = (state != IDLE) || job.go || done;

    assign tile.beat = beat;
    assign tile.sel  = b_side ? tile_loader_pkg::OPERAND_B : tile_loader_pkg::OPERAND_A;
    assign tile.row  = beat_cnt;
    assign tile.base = `DIM_W'(cur_idx * `TILE_DIM);
    assign tile.last = last_beat;

    a_valid_in_load: assert property (
        @(posedge clk) disable iff (!rstn)
        dma_valid |-> in_load
    );

    a_no_req_in_load: assert property (
        @(posedge clk) disable iff (!rstn)
        dma_req |-> !in_load
    );

endmodule

// File: edge_mask.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

module edge_mask (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`BEAT_W-1:0]        dma_data,
    output logic                      buf_wr,
    output tile_loader_pkg::operand_e buf_sel,
    output logic [`ROW_W-1:0]         buf_row,
    output logic [`BEAT_W-1:0]        buf_data,
    job_if.mask                       job,
    tile_if.mask                      tile
);

    logic [`DIM_W-1:0] limit;
    logic              mode;
    logic [`DIM_W:0]   row_pos;
    logic [`BEAT_W-1:0] masked;

    assign limit   = (tile.sel == tile_loader_pkg::OPERAND_B) ? job.job.n : job.job.m;
    assign mode    = (tile.sel == tile_loader_pkg::OPERAND_B) ? job.job.mode_b
                                                              : job.job.mode_a;
    assign row_pos = {1'b0, tile.base} + (`DIM_W+1)'(tile.row);

    always_comb begin
        masked = dma_data;
        if (mode) begin
            // Lane j is element base + j in column layout
            for (int j = 0; j < `BEAT_BYTES; j++) begin
                if (({1'b0, tile.base} + (`DIM_W+1)'(j)) >= {1'b0, limit}) begin
                    masked[8*j +: 8] = 8'h00;
                end
            end
        end else if (row_pos >= {1'b0, limit}) begin
            masked = '0;   // Whole row past the edge
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_wr <= 1'b0;
        end else begin
            buf_wr <= tile.beat;
        end
    end

    always_ff @(posedge clk) begin
        if (tile.beat) begin
            buf_sel  <= tile.sel;
            buf_row  <= tile.row;
            buf_data <= masked;
        end
    end

    a_no_wr_after_reset: assert property (
        @(posedge clk)
        !rstn |=> !buf_wr
    );

endmodule

// File: tile_loader_top.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

module tile_loader_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  logic [`ADDR_W-1:0]        addr_base_a,
    input  logic [`ADDR_W-1:0]        addr_base_b,
    input  logic [`DIM_W-1:0]         m,
    input  logic [`DIM_W-1:0]         n,
    input  logic                      mode_a,
    input  logic                      mode_b,
    output logic                      busy,
    output logic                      job_error,
    output logic                      done,
    output logic                      dma_req,
    output logic [`ADDR_W-1:0]        dma_addr,
    input  logic                      dma_valid,
    input  logic [`BEAT_W-1:0]        dma_data,
    output logic                      buf_wr,
    output tile_loader_pkg::operand_e buf_sel,
    output logic [`ROW_W-1:0]         buf_row,
    output logic [`BEAT_W-1:0]        buf_data
);

    job_if  job_bus ();
    tile_if tile_bus ();

    job_decode u_decode (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .addr_base_a (addr_base_a),
        .addr_base_b (addr_base_b),
        .m           (m),
        .n           (n),
        .mode_a      (mode_a),
        .mode_b      (mode_b),
        .busy        (busy),
        .job_error   (job_error),
        .job         (job_bus.decode)
    );

    tile_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .dma_valid (dma_valid),
        .dma_req   (dma_req),
        .dma_addr  (dma_addr),
        .busy      (busy),
        .done      (done),
        .job       (job_bus.seq),
        .tile      (tile_bus.seq)
    );

    edge_mask u_mask (
        .clk      (clk),
        .rstn     (rstn),
        .dma_data (dma_data),
        .buf_wr   (buf_wr),
        .buf_sel  (buf_sel),
        .buf_row  (buf_row),
        .buf_data (buf_data),
        .job      (job_bus.mask),
        .tile     (tile_bus.mask)
    );

endmodule

// File: tb_tile_loader.sv
`timescale 1ns/10ps
`include "tile_loader_params.svh"

module tb_tile_loader;

    localparam int NUM_JOBS = 6;
    localparam int GAP_MAX  = 3;   // Longest DMA gap in cycles

    typedef struct packed {
        logic [`ADDR_W-1:0] base_a;
        logic [`ADDR_W-1:0] base_b;
        logic [`DIM_W-1:0]  m;
        logic [`DIM_W-1:0]  n;
        logic               mode_a;
        logic               mode_b;
        logic               exp_err;
    } job_row_t;

    logic                      clk = 1'b0;
    logic                      rstn;
    logic                      start;
    logic [`ADDR_W-1:0]        addr_base_a;
    logic [`ADDR_W-1:0]        addr_base_b;
    logic [`DIM_W-1:0]         m;
    logic [`DIM_W-1:0]         n;
    logic                      mode_a;
    logic                      mode_b;
    logic                      busy;
    logic                      job_error;
    logic                      done;
    logic                      dma_req;
    logic [`ADDR_W-1:0]        dma_addr;
    logic                      dma_valid;
    logic [`BEAT_W-1:0]        dma_data;
    logic                      buf_wr;
    tile_loader_pkg::operand_e buf_sel;
    logic [`ROW_W-1:0]         buf_row;
    logic [`BEAT_W-1:0]        buf_data;

    job_row_t           jobs [NUM_JOBS];
    logic [`ADDR_W-1:0] addr_q [$];    // Expected DMA addresses
    logic               sel_q [$];
    logic [`ROW_W-1:0]  row_q [$];
    logic [`BEAT_W-1:0] data_q [$];
    int                 errors = 0;
    int                 write_count = 0;
    int                 watchdog_cycles = 0;
    integer             seed = 46309;

    tile_loader_top UUT (.*);

    always #50 clk = ~clk;

    task automatic compare_value(input string name, input logic [`BEAT_W-1:0] got,
                                 input logic [`BEAT_W-1:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expected,
                     $time);
        end
    endtask

    function automatic int tile_count(input int dim);
        return (dim + `TILE_DIM - 1) / `TILE_DIM;
    endfunction

    // Byte j of row r holds the low byte of its own address
    function automatic logic [`BEAT_W-1:0] beat_bytes(input logic [`ADDR_W-1:0] tile_addr,
                                                      input int row);
        logic [`BEAT_W-1:0] d;
        logic [`ADDR_W-1:0] byte_addr;
        for (int j = 0; j < `BEAT_BYTES; j++) begin
            byte_addr    = tile_addr + `ADDR_W'(row * `BEAT_BYTES + j);
            d[8*j +: 8]  = byte_addr[7:0];
        end
        return d;
    endfunction

    function automatic logic [`BEAT_W-1:0] expected_beat(input logic [`ADDR_W-1:0] tile_addr,
            input int row, input int first, input int limit, input logic col_layout);
        logic [`BEAT_W-1:0] d;
        int                 elem;
        d = beat_bytes(tile_addr, row);
        for (int j = 0; j < `BEAT_BYTES; j++) begin
            elem = col_layout ? first + j : first + row;   // Matrix element of lane j
            if (elem >= limit) begin
                d[8*j +: 8] = 8'h00;
            end
        end
        return d;
    endfunction

    task automatic queue_job_expect(input job_row_t jr, input int m_tiles, input int n_tiles);
        logic [`ADDR_W-1:0] a_addr;
        logic [`ADDR_W-1:0] b_addr;
        for (int mi = 0; mi < m_tiles; mi++) begin
            for (int ni = 0; ni < n_tiles; ni++) begin
                a_addr = jr.base_a + `ADDR_W'(mi * `TILE_DIM * `BEAT_BYTES);
                b_addr = jr.base_b + `ADDR_W'(ni * `TILE_DIM * `BEAT_BYTES);
                addr_q.push_back(a_addr);
                for (int r = 0; r < `TILE_DIM; r++) begin
                    sel_q.push_back(1'b0);
                    row_q.push_back(`ROW_W'(r));
                    data_q.push_back(expected_beat(a_addr, r, mi * `TILE_DIM, int'(jr.m),
                                                   jr.mode_a));
                end
                addr_q.push_back(b_addr);
                for (int r = 0; r < `TILE_DIM; r++) begin
                    sel_q.push_back(1'b1);
                    row_q.push_back(`ROW_W'(r));
                    data_q.push_back(expected_beat(b_addr, r, ni * `TILE_DIM, int'(jr.n),
                                                   jr.mode_b));
                end
            end
        end
    endtask

    task automatic run_job(input int idx);
        job_row_t jr;
        int       m_tiles;
        int       n_tiles;
        jr      = jobs[idx];
        m_tiles = tile_count(int'(jr.m));
        n_tiles = tile_count(int'(jr.n));
        if (!jr.exp_err) begin
            queue_job_expect(jr, m_tiles, n_tiles);
        end
        write_count = 0;
        @(posedge clk);
        start       <= 1'b1;
        addr_base_a <= jr.base_a;
        addr_base_b <= jr.base_b;
        m           <= jr.m;
        n           <= jr.n;
        mode_a      <= jr.mode_a;
        mode_b      <= jr.mode_b;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        compare_value("job_error", job_error, jr.exp_err);
        compare_value("busy", busy, !jr.exp_err);
        if (jr.exp_err) begin
            repeat (8) @(posedge clk);
            compare_value("busy", busy, 1'b0);
            compare_value("buf_wr count", write_count, 0);
        end else begin
            start       <= 1'b1;   // Zero m would error if taken
            m           <= '0;
            addr_base_a <= ~jr.base_a;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            compare_value("job_error", job_error, 1'b0);
            do @(posedge clk); while (!done);
            @(posedge clk);
            compare_value("busy", busy, 1'b0);
            compare_value("buf_wr count", write_count, 2 * m_tiles * n_tiles * `TILE_DIM);
            compare_value("DMA requests left", addr_q.size(), 0);
            compare_value("buffer writes left", data_q.size(), 0);
        end
    endtask

    // DMA model answers each request with one tile of beats
    initial begin : dma_model
        logic [`ADDR_W-1:0] tile_addr;
        int                 gap;
        forever begin
            @(posedge clk);
            if (rstn && dma_req) begin
                tile_addr = dma_addr;
                for (int r = 0; r < `TILE_DIM; r++) begin
                    gap = int'($unsigned($random(seed)) % (GAP_MAX + 1));
                    repeat (gap) begin
                        dma_valid <= 1'b0;
                        @(posedge clk);
                    end
                    dma_valid <= 1'b1;
                    dma_data  <= beat_bytes(tile_addr, r);
                    @(posedge clk);
                end
                dma_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && dma_req) begin
            if (addr_q.size() == 0) begin
                errors++;
                $display("Unexpected DMA request to address 0x%0h at %0t", dma_addr, $time);
            end else begin
                compare_value("dma_addr", dma_addr, addr_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && buf_wr) begin
            write_count++;
            if (data_q.size() == 0) begin
                errors++;
                $display("Buffer write that no beat accounts for at %0t", $time);
            end else begin
                compare_value("buf_sel", buf_sel, sel_q.pop_front());
                compare_value("buf_row", buf_row, row_q.pop_front());
                compare_value("buf_data", buf_data, data_q.pop_front());
                compare_value("done", done, data_q.size() == 0);   // Only on the last write
            end
        end else if (rstn && done) begin
            errors++;
            $display("done pulsed without a buffer write at %0t", $time);
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout, the jobs did not finish within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        int total_tiles;
        rstn        = 1'b0;
        start       = 1'b0;
        addr_base_a = '0;
        addr_base_b = '0;
        m           = '0;
        n           = '0;
        mode_a      = 1'b0;
        mode_b      = 1'b0;
        dma_valid   = 1'b0;
        dma_data    = '0;
        // base_a, base_b, m, n, mode_a, mode_b, exp_err
        jobs[0] = '{32'h0000_1000, 32'h0004_0000, 16'd64, 16'd64, 1'b0, 1'b0, 1'b0};
        jobs[1] = '{32'h0001_0000, 32'h0005_0200, 16'd40, 16'd32, 1'b0, 1'b0, 1'b0};
        jobs[2] = '{32'h0002_0040, 32'h0006_0000, 16'd20, 16'd50, 1'b1, 1'b1, 1'b0};
        jobs[3] = '{32'h0003_0000, 32'h0007_0000, 16'd0,  16'd32, 1'b0, 1'b0, 1'b1};
        jobs[4] = '{32'h0003_0000, 32'h0007_0000, 16'd32, 16'd0,  1'b1, 1'b1, 1'b1};
        jobs[5] = '{32'h0000_10F0, 32'h0008_3F3B, 16'd45, 16'd70, 1'b0, 1'b1, 1'b0};
        total_tiles = 0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            if (!jobs[i].exp_err) begin
                total_tiles += 2 * tile_count(int'(jobs[i].m)) * tile_count(int'(jobs[i].n));
            end
        end
        // Worst case per tile is every beat behind a full gap
        watchdog_cycles = 200 + NUM_JOBS * 20 + total_tiles * (4 + `TILE_DIM * (GAP_MAX + 1));
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_JOBS; i++) begin
            run_job(i);
        end
        repeat (5) @(posedge clk);
        $display("Tile loader run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
tile_loader_pkg.sv
job_if.sv
tile_if.sv
job_decode.sv
tile_sequencer.sv
edge_mask.sv
tile_loader_top.sv
tb_tile_loader.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_loader \
    -f list.f -o tb_tile_loader > build.log 2>&1 \
    && ./obj_dir/tb_tile_loader > sim.log 2>&1 \
    || echo "Build or simulation step did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log 2>/dev/null && exit 0 || exit 1
